// File: hw/pr_cfg_pkg.sv
package pr_cfg_pkg;

  localparam int DATA_WIDTH      = 128;
  localparam int STRB_WIDTH      = DATA_WIDTH / 8;
  localparam int DMA_ADDR_WIDTH  = 26;

  // 32 KiB of packet memory, the top 8 KiB take broadcast messages
  localparam int PMEM_LINES      = 2048;
  localparam int PMEM_LINE_WIDTH = $clog2(PMEM_LINES);
  localparam int BC_REGION_LINES = 512;
  localparam int BC_BASE_LINE    = PMEM_LINES - BC_REGION_LINES;

  // Broadcast word address, strobes and data
  localparam int BC_ADDR_WIDTH   = 11;
  localparam int MSG_WIDTH       = 32 + 4 + BC_ADDR_WIDTH;

  localparam int STATUS_SLOTS      = 8;
  localparam int CORE_STATUS_SLOTS = 4;

endpackage

// File: hw/pr_msg_pkg.sv
package pr_msg_pkg;

  typedef struct packed {
    logic [pr_cfg_pkg::DATA_WIDTH-1:0]     data;
    logic [pr_cfg_pkg::DMA_ADDR_WIDTH-1:0] addr;
    logic [pr_cfg_pkg::STRB_WIDTH-1:0]     strb;
    logic                                  last;
  } dma_wr_t;

  typedef struct packed {
    logic [pr_cfg_pkg::DMA_ADDR_WIDTH-1:0] addr;
    logic                                  last;
  } dma_rd_t;

  typedef struct packed {
    logic [pr_cfg_pkg::BC_ADDR_WIDTH-1:0] addr;
    logic [3:0]                           strb;
    logic [31:0]                          data;
  } bc_msg_t;

  typedef enum logic [3:0] {
    PKT  = 4'd1,
    CTRL = 4'd2
  } desc_type_e;

  typedef struct packed {
    desc_type_e  typ;
    logic [3:0]  port;
    logic [7:0]  tag;
    logic [15:0] len;
    logic [31:0] buf_addr;
  } desc_pkt_t;

  typedef struct packed {
    desc_type_e                           typ;
    logic [12:0]                          spare;
    logic [pr_cfg_pkg::BC_ADDR_WIDTH-1:0] bc_addr;
    logic [3:0]                           strb;
    logic [31:0]                          data;
  } desc_ctrl_t;

  // Type sits in the top nibble of both views
  typedef union packed {
    desc_pkt_t  pkt;
    desc_ctrl_t ctrl;
  } desc_u;

  typedef struct packed {
    logic  second;
    desc_u desc;
  } out_desc_t;

endpackage

// File: hw/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] s_data,
  input  logic             s_valid,
  output logic             s_ready,
  output logic [WIDTH-1:0] m_data,
  output logic             m_valid,
  input  logic             m_ready
);

  logic [WIDTH-1:0] skid_data;
  logic             skid_valid;

  // Ready comes straight from a flop
  assign s_ready = ~skid_valid;

  always_ff @(posedge clk) begin
    if (m_ready || !m_valid) begin
      m_data <= skid_valid ? skid_data : s_data;
    end else if (s_valid && s_ready) begin
      skid_data <= s_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (m_ready || !m_valid) begin
      m_valid    <= skid_valid || s_valid;
      skid_valid <= 1'b0;
    end else if (s_valid && s_ready) begin
      skid_valid <= 1'b1;
    end
  end

  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_data)));

endmodule

// File: hw/pkt_mem.sv
`timescale 1ns/1ps

module pkt_mem (
  input  logic                              clk,
  input  logic                              rst,
  input  pr_msg_pkg::dma_wr_t               wr,
  input  logic                              wr_valid,
  output logic                              wr_ready,
  input  pr_msg_pkg::dma_rd_t               rd,
  input  logic                              rd_valid,
  output logic                              rd_ready,
  output logic [pr_cfg_pkg::DATA_WIDTH-1:0] resp_data,
  output logic                              resp_valid,
  input  logic                              resp_ready,
  input  pr_msg_pkg::bc_msg_t               bc_in,
  input  logic                              bc_in_valid
);

  import pr_cfg_pkg::*;

  logic [DATA_WIDTH-1:0] mem [PMEM_LINES];

  logic [PMEM_LINE_WIDTH-1:0] wr_line, rd_line, bc_line;
  logic [PMEM_LINE_WIDTH-1:0] wq_line;
  logic [DATA_WIDTH-1:0]      wq_data;
  logic [STRB_WIDTH-1:0]      wq_strb;
  logic                       wq_valid;
  logic                       rd_start;

  assign wr_line = wr.addr[$clog2(STRB_WIDTH) +: PMEM_LINE_WIDTH];
  assign rd_line = rd.addr[$clog2(STRB_WIDTH) +: PMEM_LINE_WIDTH];
  assign bc_line = PMEM_LINE_WIDTH'(BC_BASE_LINE) +
                   PMEM_LINE_WIDTH'(bc_in.addr[BC_ADDR_WIDTH-1:2]);

  // Broadcast takes the single write port first
  assign wr_ready = ~bc_in_valid;

  // Reads wait for a pending write so they never see stale data
  assign rd_ready = (!resp_valid || resp_ready) && !wq_valid;
  assign rd_start = rd_valid && rd_ready;

  always_ff @(posedge clk) begin
    if (bc_in_valid) begin
      wq_line <= bc_line;
      wq_data <= {(DATA_WIDTH / 32){bc_in.data}};
      wq_strb <= STRB_WIDTH'(bc_in.strb) << {bc_in.addr[1:0], 2'b00};
    end else begin
      wq_line <= wr_line;
      wq_data <= wr.data;
      wq_strb <= wr.strb;
    end
    if (wq_valid) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (wq_strb[b]) mem[wq_line][8*b +: 8] <= wq_data[8*b +: 8];
      end
    end
    if (rd_start) resp_data <= mem[rd_line];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wq_valid   <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      wq_valid <= bc_in_valid || (wr_valid && wr_ready);
      if (rd_start) resp_valid <= 1'b1;
      else if (resp_ready) resp_valid <= 1'b0;
    end
  end

  // A full response register is not overwritten by a new read
  a_no_overrun: assert property (@(posedge clk) disable iff (rst)
    (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp_data)));

endmodule

// File: hw/desc_engine.sv
`timescale 1ns/1ps

module desc_engine (
  input  logic                  clk,
  input  logic                  rst,
  input  pr_msg_pkg::desc_u     in_desc,
  input  logic                  in_valid,
  output logic                  in_taken,
  output pr_msg_pkg::out_desc_t out_desc,
  output logic                  out_valid,
  input  logic                  out_ready,
  output pr_msg_pkg::bc_msg_t   bc_out,
  output logic                  bc_out_valid,
  input  logic                  bc_out_ready,
  output logic                  pkt_done,
  output logic                  ctrl_done
);

  import pr_msg_pkg::*;

  desc_u fwd;
  logic  is_pkt, is_ctrl;
  logic  out_free, bc_free;
  logic  accept;

  assign is_pkt   = in_desc.pkt.typ == PKT;
  assign is_ctrl  = in_desc.ctrl.typ == CTRL;
  assign out_free = !out_valid || out_ready;
  assign bc_free  = !bc_out_valid || bc_out_ready;

  // Unknown types are always taken and dropped
  assign in_taken  = is_pkt ? out_free : (is_ctrl ? bc_free : 1'b1);
  assign accept    = in_valid && in_taken;
  assign pkt_done  = accept && is_pkt;
  assign ctrl_done = accept && is_ctrl;

  always_comb begin
    fwd             = in_desc;
    fwd.pkt.port[0] = ~in_desc.pkt.port[0];
  end

  always_ff @(posedge clk) begin
    if (pkt_done) out_desc <= '{second: 1'b0, desc: fwd};
    if (ctrl_done) begin
      bc_out <= '{addr: in_desc.ctrl.bc_addr, strb: in_desc.ctrl.strb,
                  data: in_desc.ctrl.data};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid    <= 1'b0;
      bc_out_valid <= 1'b0;
    end else begin
      out_valid    <= pkt_done || (out_valid && !out_ready);
      bc_out_valid <= ctrl_done || (bc_out_valid && !bc_out_ready);
    end
  end

  // Both outputs freshly loaded would mean one descriptor fed both
  a_one_output: assert property (@(posedge clk) disable iff (rst)
    accept |=> !(out_valid && bc_out_valid && $past(out_free && bc_free)));

endmodule

// File: hw/status_regs.sv
`timescale 1ns/1ps

module status_regs (
  input  logic                                            clk,
  input  logic                                            rst,
  input  logic                                            core_reset,
  input  logic [31:0]                                     wrapper_status_data,
  input  logic [$clog2(pr_cfg_pkg::STATUS_SLOTS)-1:0]      wrapper_status_addr,
  input  logic                                            pkt_done,
  input  logic                                            ctrl_done,
  input  logic                                            bc_in_valid,
  output logic [31:0]                                     core_status_data,
  output logic [$clog2(pr_cfg_pkg::CORE_STATUS_SLOTS)-1:0] core_status_addr
);

  import pr_cfg_pkg::*;

  logic [31:0] ws_regs [STATUS_SLOTS];
  logic [31:0] pkt_cnt, ctrl_cnt, bc_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < STATUS_SLOTS; i++) ws_regs[i] <= '0;
      core_status_addr <= '0;
    end else begin
      ws_regs[wrapper_status_addr] <= wrapper_status_data;
      core_status_addr             <= core_status_addr + 1'b1;
    end
  end

  // Counters also follow the core reset
  always_ff @(posedge clk) begin
    if (core_reset) begin
      pkt_cnt  <= '0;
      ctrl_cnt <= '0;
      bc_cnt   <= '0;
    end else begin
      pkt_cnt  <= pkt_cnt + 32'(pkt_done);
      ctrl_cnt <= ctrl_cnt + 32'(ctrl_done);
      bc_cnt   <= bc_cnt + 32'(bc_in_valid);
    end
  end

  always_comb begin
    case (core_status_addr)
      2'd0:    core_status_data = pkt_cnt;
      2'd1:    core_status_data = ctrl_cnt;
      2'd2:    core_status_data = bc_cnt;
      default: core_status_data = ws_regs[0];
    endcase
  end

endmodule

// File: hw/pr_core.sv
`timescale 1ns/1ps

module pr_core (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              core_reset,
  input  pr_msg_pkg::dma_wr_t               dma_cmd_wr,
  input  logic                              dma_cmd_wr_en,
  output logic                              dma_cmd_wr_ready,
  input  pr_msg_pkg::dma_rd_t               dma_cmd_rd,
  input  logic                              dma_cmd_rd_en,
  output logic                              dma_cmd_rd_ready,
  output logic [pr_cfg_pkg::DATA_WIDTH-1:0] dma_rd_resp_data,
  output logic                              dma_rd_resp_valid,
  input  logic                              dma_rd_resp_ready,
  input  pr_msg_pkg::desc_u                 in_desc,
  input  logic                              in_desc_valid,
  output logic                              in_desc_taken,
  output pr_msg_pkg::out_desc_t             out_desc,
  output logic                              out_desc_valid,
  input  logic                              out_desc_ready,
  input  pr_msg_pkg::bc_msg_t               bc_msg_in,
  input  logic                              bc_msg_in_valid,
  output pr_msg_pkg::bc_msg_t               bc_msg_out,
  output logic                              bc_msg_out_valid,
  input  logic                              bc_msg_out_ready,
  input  logic [31:0]                       wrapper_status_data,
  input  logic [2:0]                        wrapper_status_addr,
  output logic [31:0]                       core_status_data,
  output logic [1:0]                        core_status_addr
);

  import pr_msg_pkg::*;

  logic      core_rst;
  logic      pkt_done, ctrl_done;
  out_desc_t eng_desc;

  assign core_rst = rst || core_reset;

  // No second descriptors from this core
  assign out_desc = '{second: 1'b0, desc: eng_desc.desc};

  //////////////////////////////////////////////////////////////////////
  // Packet memory
  //////////////////////////////////////////////////////////////////////
  pkt_mem u_pkt_mem (
    .clk(clk), .rst(rst),
    .wr(dma_cmd_wr), .wr_valid(dma_cmd_wr_en), .wr_ready(dma_cmd_wr_ready),
    .rd(dma_cmd_rd), .rd_valid(dma_cmd_rd_en), .rd_ready(dma_cmd_rd_ready),
    .resp_data(dma_rd_resp_data), .resp_valid(dma_rd_resp_valid),
    .resp_ready(dma_rd_resp_ready),
    .bc_in(bc_msg_in), .bc_in_valid(bc_msg_in_valid)
  );

  //////////////////////////////////////////////////////////////////////
  // Descriptors and status
  //////////////////////////////////////////////////////////////////////
  desc_engine u_desc_engine (
    .clk(clk), .rst(core_rst),
    .in_desc(in_desc), .in_valid(in_desc_valid), .in_taken(in_desc_taken),
    .out_desc(eng_desc), .out_valid(out_desc_valid), .out_ready(out_desc_ready),
    .bc_out(bc_msg_out), .bc_out_valid(bc_msg_out_valid),
    .bc_out_ready(bc_msg_out_ready),
    .pkt_done(pkt_done), .ctrl_done(ctrl_done)
  );

  status_regs u_status_regs (
    .clk(clk), .rst(rst), .core_reset(core_rst),
    .wrapper_status_data(wrapper_status_data),
    .wrapper_status_addr(wrapper_status_addr),
    .pkt_done(pkt_done), .ctrl_done(ctrl_done), .bc_in_valid(bc_msg_in_valid),
    .core_status_data(core_status_data), .core_status_addr(core_status_addr)
  );

endmodule

// File: hw/core_pr_wrapper.sv
`timescale 1ns/1ps

module core_pr_wrapper (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  core_reset,
  input  logic                                  dma_cmd_wr_en,
  input  logic [pr_cfg_pkg::DMA_ADDR_WIDTH-1:0] dma_cmd_wr_addr,
  input  logic [pr_cfg_pkg::DATA_WIDTH-1:0]     dma_cmd_wr_data,
  input  logic [pr_cfg_pkg::STRB_WIDTH-1:0]     dma_cmd_wr_strb,
  input  logic                                  dma_cmd_wr_last,
  output logic                                  dma_cmd_wr_ready,
  input  logic                                  dma_cmd_rd_en,
  input  logic [pr_cfg_pkg::DMA_ADDR_WIDTH-1:0] dma_cmd_rd_addr,
  input  logic                                  dma_cmd_rd_last,
  output logic                                  dma_cmd_rd_ready,
  output logic                                  dma_rd_resp_valid,
  output logic [pr_cfg_pkg::DATA_WIDTH-1:0]     dma_rd_resp_data,
  input  logic                                  dma_rd_resp_ready,
  input  logic [63:0]                           in_desc,
  input  logic                                  in_desc_valid,
  output logic                                  in_desc_taken,
  output logic [63:0]                           out_desc,
  output logic                                  out_desc_2nd,
  output logic                                  out_desc_valid,
  input  logic                                  out_desc_ready,
  input  logic [pr_cfg_pkg::MSG_WIDTH-1:0]      bc_msg_in,
  input  logic                                  bc_msg_in_valid,
  output logic [pr_cfg_pkg::MSG_WIDTH-1:0]      bc_msg_out,
  output logic                                  bc_msg_out_valid,
  input  logic                                  bc_msg_out_ready,
  input  logic [31:0]                           wrapper_status_data,
  input  logic [2:0]                            wrapper_status_addr,
  output logic [31:0]                           core_status_data,
  output logic [1:0]                            core_status_addr
);

  import pr_cfg_pkg::*;
  import pr_msg_pkg::*;

  logic rst_r, core_reset_r, core_rst;

  dma_wr_t               wr_s, wr_m;
  dma_rd_t               rd_s, rd_m;
  logic                  wr_m_valid, wr_m_ready, rd_m_valid, rd_m_ready;
  logic [DATA_WIDTH-1:0] resp_c_data;
  logic                  resp_c_valid, resp_c_ready;
  desc_u                 in_desc_m;
  logic                  in_desc_m_valid, in_desc_m_taken;
  out_desc_t             out_desc_c, out_desc_m;
  logic                  out_desc_c_valid, out_desc_c_ready;
  bc_msg_t               bc_in_m, bc_out_c;
  logic                  bc_in_m_valid, bc_out_c_valid, bc_out_c_ready;
  logic [31:0]           ws_data_r, cs_data_c;
  logic [2:0]            ws_addr_r;
  logic [1:0]            cs_addr_c;

  //////////////////////////////////////////////////////////////////////
  // Registered resets and status
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    rst_r            <= rst;
    core_reset_r     <= core_reset;
    ws_data_r        <= wrapper_status_data;
    ws_addr_r        <= wrapper_status_addr;
    core_status_data <= cs_data_c;
    core_status_addr <= cs_addr_c;
  end

  assign core_rst = rst_r || core_reset_r;

  assign wr_s = '{data: dma_cmd_wr_data, addr: dma_cmd_wr_addr,
                  strb: dma_cmd_wr_strb, last: dma_cmd_wr_last};
  assign rd_s = '{addr: dma_cmd_rd_addr, last: dma_cmd_rd_last};

  assign out_desc     = out_desc_m.desc;
  assign out_desc_2nd = out_desc_m.second;

  //////////////////////////////////////////////////////////////////////
  // Channel stages
  //////////////////////////////////////////////////////////////////////
  pipe_reg #(.WIDTH($bits(dma_wr_t))) u_wr_reg (
    .clk(clk), .rst(rst_r),
    .s_data(wr_s), .s_valid(dma_cmd_wr_en), .s_ready(dma_cmd_wr_ready),
    .m_data(wr_m), .m_valid(wr_m_valid), .m_ready(wr_m_ready)
  );

  pipe_reg #(.WIDTH($bits(dma_rd_t))) u_rd_reg (
    .clk(clk), .rst(rst_r),
    .s_data(rd_s), .s_valid(dma_cmd_rd_en), .s_ready(dma_cmd_rd_ready),
    .m_data(rd_m), .m_valid(rd_m_valid), .m_ready(rd_m_ready)
  );

  pipe_reg #(.WIDTH(DATA_WIDTH)) u_resp_reg (
    .clk(clk), .rst(rst_r),
    .s_data(resp_c_data), .s_valid(resp_c_valid), .s_ready(resp_c_ready),
    .m_data(dma_rd_resp_data), .m_valid(dma_rd_resp_valid),
    .m_ready(dma_rd_resp_ready)
  );

  pipe_reg #(.WIDTH($bits(desc_u))) u_in_desc_reg (
    .clk(clk), .rst(core_rst),
    .s_data(in_desc), .s_valid(in_desc_valid), .s_ready(in_desc_taken),
    .m_data(in_desc_m), .m_valid(in_desc_m_valid), .m_ready(in_desc_m_taken)
  );

  pipe_reg #(.WIDTH($bits(out_desc_t))) u_out_desc_reg (
    .clk(clk), .rst(core_rst),
    .s_data(out_desc_c), .s_valid(out_desc_c_valid), .s_ready(out_desc_c_ready),
    .m_data(out_desc_m), .m_valid(out_desc_valid), .m_ready(out_desc_ready)
  );

  // Broadcast input has no back-pressure
  pipe_reg #(.WIDTH(MSG_WIDTH)) u_bc_in_reg (
    .clk(clk), .rst(core_rst),
    .s_data(bc_msg_in), .s_valid(bc_msg_in_valid), .s_ready(),
    .m_data(bc_in_m), .m_valid(bc_in_m_valid), .m_ready(1'b1)
  );

  pipe_reg #(.WIDTH(MSG_WIDTH)) u_bc_out_reg (
    .clk(clk), .rst(rst_r),
    .s_data(bc_out_c), .s_valid(bc_out_c_valid), .s_ready(bc_out_c_ready),
    .m_data(bc_msg_out), .m_valid(bc_msg_out_valid), .m_ready(bc_msg_out_ready)
  );

  pr_core u_pr_core (
    .clk(clk), .rst(rst_r), .core_reset(core_reset_r),
    .dma_cmd_wr(wr_m), .dma_cmd_wr_en(wr_m_valid), .dma_cmd_wr_ready(wr_m_ready),
    .dma_cmd_rd(rd_m), .dma_cmd_rd_en(rd_m_valid), .dma_cmd_rd_ready(rd_m_ready),
    .dma_rd_resp_data(resp_c_data), .dma_rd_resp_valid(resp_c_valid),
    .dma_rd_resp_ready(resp_c_ready),
    .in_desc(in_desc_m), .in_desc_valid(in_desc_m_valid),
    .in_desc_taken(in_desc_m_taken),
    .out_desc(out_desc_c), .out_desc_valid(out_desc_c_valid),
    .out_desc_ready(out_desc_c_ready),
    .bc_msg_in(bc_in_m), .bc_msg_in_valid(bc_in_m_valid),
    .bc_msg_out(bc_out_c), .bc_msg_out_valid(bc_out_c_valid),
    .bc_msg_out_ready(bc_out_c_ready),
    .wrapper_status_data(ws_data_r), .wrapper_status_addr(ws_addr_r),
    .core_status_data(cs_data_c), .core_status_addr(cs_addr_c)
  );

endmodule

// File: verif/tb_core_pr_wrapper.sv
`timescale 1ns/1ps

module tb_core_pr_wrapper;

  localparam int CLK_PERIOD = 20;
  // Generous per-test cycle estimates, summed
  localparam int TEST_CYCLES = 200 + 400 + 600 + 500 + 600 + 200;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 500;
  localparam int BC_BASE = 1536;
  localparam logic [63:0] PORT0_FLIP = 64'h0100_0000_0000_0000;

  logic         clk, rst, core_reset;
  logic         dma_cmd_wr_en, dma_cmd_wr_last, dma_cmd_wr_ready;
  logic [25:0]  dma_cmd_wr_addr;
  logic [127:0] dma_cmd_wr_data;
  logic [15:0]  dma_cmd_wr_strb;
  logic         dma_cmd_rd_en, dma_cmd_rd_last, dma_cmd_rd_ready;
  logic [25:0]  dma_cmd_rd_addr;
  logic         dma_rd_resp_valid, dma_rd_resp_ready;
  logic [127:0] dma_rd_resp_data;
  logic [63:0]  in_desc, out_desc;
  logic         in_desc_valid, in_desc_taken;
  logic         out_desc_2nd, out_desc_valid, out_desc_ready;
  logic [46:0]  bc_msg_in, bc_msg_out;
  logic         bc_msg_in_valid, bc_msg_out_valid, bc_msg_out_ready;
  logic [31:0]  wrapper_status_data, core_status_data;
  logic [2:0]   wrapper_status_addr;
  logic [1:0]   core_status_addr;

  // Reference model
  logic [127:0] model_mem [2048];
  logic [127:0] exp_resp [64];
  logic [63:0]  exp_desc [64];
  logic [46:0]  exp_bc [64];
  logic [31:0]  status_exp [4];
  int           resp_push, resp_pop, desc_push, desc_pop, bc_push, bc_pop;

  integer       seed = 32'h33582b99;
  int           errors, test_errors, tests_failed, test_num;
  logic         shake_ready, resp_hold, status_check;
  logic [2:0]   ready_bits;

  wire [127:0] resp_exp    = exp_resp[resp_pop];
  wire [63:0]  desc_exp    = exp_desc[desc_pop];
  wire [46:0]  bc_exp      = exp_bc[bc_pop];
  wire [31:0]  status_word = status_exp[core_status_addr];

  core_pr_wrapper u_core_pr_wrapper (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Output ready lines, random while a test shakes them
  initial begin
    out_desc_ready    = 1'b1;
    bc_msg_out_ready  = 1'b1;
    dma_rd_resp_ready = 1'b1;
    forever begin
      @(negedge clk);
      ready_bits        = 3'($random(seed));
      out_desc_ready    = !shake_ready || ready_bits[0];
      bc_msg_out_ready  = !shake_ready || ready_bits[1];
      dma_rd_resp_ready = !resp_hold && (!shake_ready || ready_bits[2]);
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      resp_pop <= 0;
      desc_pop <= 0;
      bc_pop   <= 0;
    end else begin
      if (dma_rd_resp_valid && dma_rd_resp_ready) resp_pop <= resp_pop + 1;
      if (out_desc_valid && out_desc_ready) desc_pop <= desc_pop + 1;
      if (bc_msg_out_valid && bc_msg_out_ready) bc_pop <= bc_pop + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output checks
  //////////////////////////////////////////////////////////////////////
  a_resp_extra: assert property (@(posedge clk) disable iff (rst)
    (dma_rd_resp_valid && dma_rd_resp_ready) |-> (resp_pop < resp_push))
    else begin
      $display("error: read response with no read outstanding");
      errors++;
    end

  a_resp_data: assert property (@(posedge clk) disable iff (rst)
    (dma_rd_resp_valid && dma_rd_resp_ready) |-> (dma_rd_resp_data == resp_exp))
    else begin
      $display("error: dma_rd_resp_data = %h, expected %h",
               $sampled(dma_rd_resp_data), $sampled(resp_exp));
      errors++;
    end

  a_desc_extra: assert property (@(posedge clk) disable iff (rst)
    (out_desc_valid && out_desc_ready) |-> (desc_pop < desc_push))
    else begin
      $display("error: out_desc sent with no packet descriptor outstanding");
      errors++;
    end

  a_desc_data: assert property (@(posedge clk) disable iff (rst)
    (out_desc_valid && out_desc_ready) |-> (out_desc == desc_exp))
    else begin
      $display("error: out_desc = %h, expected %h",
               $sampled(out_desc), $sampled(desc_exp));
      errors++;
    end

  a_desc_2nd: assert property (@(posedge clk) disable iff (rst)
    out_desc_valid |-> !out_desc_2nd)
    else begin
      $display("error: out_desc_2nd = %h, expected 0", $sampled(out_desc_2nd));
      errors++;
    end

  a_bc_extra: assert property (@(posedge clk) disable iff (rst)
    (bc_msg_out_valid && bc_msg_out_ready) |-> (bc_pop < bc_push))
    else begin
      $display("error: bc_msg_out sent with no control descriptor outstanding");
      errors++;
    end

  a_bc_data: assert property (@(posedge clk) disable iff (rst)
    (bc_msg_out_valid && bc_msg_out_ready) |-> (bc_msg_out == bc_exp))
    else begin
      $display("error: bc_msg_out = %h, expected %h",
               $sampled(bc_msg_out), $sampled(bc_exp));
      errors++;
    end

  a_status_word: assert property (@(posedge clk) disable iff (!status_check)
    core_status_data == status_word)
    else begin
      $display("error: core_status_data at %h = %h, expected %h",
               $sampled(core_status_addr), $sampled(core_status_data),
               $sampled(status_word));
      errors++;
    end

  a_status_step: assert property (@(posedge clk) disable iff (!status_check)
    core_status_addr == $past(core_status_addr) + 2'd1)
    else begin
      $display("error: core_status_addr = %h, expected %h",
               $sampled(core_status_addr), $past(core_status_addr) + 2'd1);
      errors++;
    end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic [127:0] rand_line();
    return {rand_word(), rand_word(), rand_word(), rand_word()};
  endfunction

  task automatic dma_write(input logic [10:0] line, input logic [127:0] data,
                           input logic [15:0] strb);
    logic [10:0] upper;
    upper = 11'($random(seed));
    for (int b = 0; b < 16; b++) begin
      if (strb[b]) model_mem[line][8*b +: 8] = data[8*b +: 8];
    end
    @(negedge clk);
    dma_cmd_wr_en   = 1'b1;
    dma_cmd_wr_addr = {upper, line, 4'h0};
    dma_cmd_wr_data = data;
    dma_cmd_wr_strb = strb;
    dma_cmd_wr_last = 1'b1;
    while (!dma_cmd_wr_ready) @(negedge clk);
    @(negedge clk);
    dma_cmd_wr_en = 1'b0;
  endtask

  task automatic dma_read(input logic [10:0] line);
    logic [10:0] upper;
    upper = 11'($random(seed));
    exp_resp[resp_push] = model_mem[line];
    resp_push++;
    @(negedge clk);
    dma_cmd_rd_en   = 1'b1;
    dma_cmd_rd_addr = {upper, line, 4'h0};
    dma_cmd_rd_last = 1'b1;
    while (!dma_cmd_rd_ready) @(negedge clk);
    @(negedge clk);
    dma_cmd_rd_en = 1'b0;
  endtask

  task automatic send_desc(input logic [63:0] d);
    case (d[63:60])
      4'd1: begin
        exp_desc[desc_push] = d ^ PORT0_FLIP;
        desc_push++;
        status_exp[0] = status_exp[0] + 1;
      end
      4'd2: begin
        // Control view: address 46:36, strobes 35:32, data 31:0
        exp_bc[bc_push] = {d[46:36], d[35:32], d[31:0]};
        bc_push++;
        status_exp[1] = status_exp[1] + 1;
      end
      default: ;
    endcase
    @(negedge clk);
    in_desc       = d;
    in_desc_valid = 1'b1;
    while (!in_desc_taken) @(negedge clk);
    @(negedge clk);
    in_desc_valid = 1'b0;
  endtask

  task automatic pulse_bc(input logic [10:0] addr, input logic [3:0] strb,
                          input logic [31:0] data);
    logic [10:0] line;
    line = 11'(BC_BASE) + {2'b00, addr[10:2]};
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) model_mem[line][32 * addr[1:0] + 8 * b +: 8] = data[8*b +: 8];
    end
    status_exp[2] = status_exp[2] + 1;
    @(negedge clk);
    bc_msg_in       = {addr, strb, data};
    bc_msg_in_valid = 1'b1;
    @(negedge clk);
    bc_msg_in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (resp_pop != resp_push || desc_pop != desc_push || bc_pop != bc_push) begin
      @(negedge clk);
    end
    // Idle cycles so a stray output still gets caught
    repeat (6) @(negedge clk);
  endtask

  task automatic finish_test(input string name);
    test_num++;
    if (errors == test_errors) begin
      $display("test %0d %s: passed", test_num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", test_num, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("run timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic [63:0] d;
    logic [10:0] bc_addr;
    logic [3:0]  bc_strb;
    logic [31:0] bc_data, ws_value;
    rst = 1'b1;
    core_reset = 1'b0;
    dma_cmd_wr_en = 1'b0;
    dma_cmd_wr_addr = '0;
    dma_cmd_wr_data = '0;
    dma_cmd_wr_strb = '0;
    dma_cmd_wr_last = 1'b0;
    dma_cmd_rd_en = 1'b0;
    dma_cmd_rd_addr = '0;
    dma_cmd_rd_last = 1'b0;
    in_desc = '0;
    in_desc_valid = 1'b0;
    bc_msg_in = '0;
    bc_msg_in_valid = 1'b0;
    wrapper_status_data = '0;
    wrapper_status_addr = 3'd7;
    shake_ready = 1'b0;
    resp_hold = 1'b0;
    status_check = 1'b0;
    resp_push = 0;
    desc_push = 0;
    bc_push = 0;
    errors = 0;
    test_errors = 0;
    tests_failed = 0;
    test_num = 0;
    for (int i = 0; i < 4; i++) status_exp[i] = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (2) @(negedge clk);

    dma_write(11'd5, rand_line(), 16'hffff);
    dma_write(11'd5, rand_line(), 16'h0f3c);
    dma_read(11'd5);
    wait_drained();
    finish_test("partial write merge");

    for (int i = 0; i < 8; i++) dma_write(11'(16 + i), rand_line(), 16'hffff);
    resp_hold = 1'b1;
    fork
      for (int i = 0; i < 8; i++) dma_read(11'(16 + i));
      begin
        // Let the read path back up before releasing responses
        while (dma_cmd_rd_ready) @(negedge clk);
        repeat (4) @(negedge clk);
        resp_hold = 1'b0;
        shake_ready = 1'b1;
      end
    join
    wait_drained();
    finish_test("stalled reads in order");

    for (int i = 0; i < 12; i++) begin
      d = {rand_word(), rand_word()};
      d[63:60] = 4'd1;
      send_desc(d);
    end
    wait_drained();
    finish_test("packet descriptors");

    for (int i = 0; i < 8; i++) begin
      d = {rand_word(), rand_word()};
      d[63:60] = (i == 3) ? 4'd7 : ((i == 5) ? 4'd0 : 4'd2);
      send_desc(d);
    end
    wait_drained();
    shake_ready = 1'b0;
    finish_test("control descriptors");

    for (int i = 0; i < 6; i++) dma_write(11'(BC_BASE + 5 * i + 2), rand_line(), 16'hffff);
    for (int i = 0; i < 6; i++) begin
      bc_addr = {9'(5 * i + 2), 2'(i)};
      bc_strb = 4'(rand_word()) | 4'h1;
      bc_data = rand_word();
      if (i % 2 == 0) begin
        fork
          dma_write(11'(64 + i), rand_line(), 16'hffff);
          pulse_bc(bc_addr, bc_strb, bc_data);
        join
      end else begin
        pulse_bc(bc_addr, bc_strb, bc_data);
      end
    end
    repeat (4) @(negedge clk);
    for (int i = 0; i < 6; i++) dma_read(11'(BC_BASE + 5 * i + 2));
    for (int i = 0; i < 6; i += 2) dma_read(11'(64 + i));
    wait_drained();
    finish_test("broadcast writes");

    ws_value = rand_word();
    @(negedge clk);
    wrapper_status_addr = 3'd0;
    wrapper_status_data = ws_value;
    @(negedge clk);
    wrapper_status_addr = 3'd3;
    wrapper_status_data = rand_word();
    status_exp[3] = ws_value;
    repeat (4) @(negedge clk);
    status_check = 1'b1;
    repeat (8) @(negedge clk);
    status_check = 1'b0;
    core_reset = 1'b1;
    @(negedge clk);
    core_reset = 1'b0;
    for (int i = 0; i < 3; i++) status_exp[i] = '0;
    repeat (4) @(negedge clk);
    status_check = 1'b1;
    repeat (8) @(negedge clk);
    status_check = 1'b0;
    finish_test("status rotation and core reset");

    $display("tests %0d, failed %0d, errors %0d", test_num, tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: compile.f
hw/pr_cfg_pkg.sv
hw/pr_msg_pkg.sv
hw/pipe_reg.sv
hw/pkt_mem.sv
hw/desc_engine.sv
hw/status_regs.sv
hw/pr_core.sv
hw/core_pr_wrapper.sv
verif/tb_core_pr_wrapper.sv

// File: run_sim.sh
#!/bin/sh
# Build and run with Verilator, the pass line in the output decides
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_core_pr_wrapper -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -qx "Everything OK" &&
echo "run_sim: pass" || { echo "run_sim: fail"; exit 1; }
